// ==== design/rs_pkg.sv ====
package rs_pkg;

    //////////////////////////////////////////////////
    // Data path widths
    //////////////////////////////////////////////////

    localparam int XLEN    = 32;  // Operand and result width
    localparam int TAG_W   = 5;   // ROBEN width, tag 0 means the value is already valid
    localparam int OPC_W   = 12;  // Opcode field width
    localparam int ALUOP_W = 4;   // ALU operation field width

    //////////////////////////////////////////////////
    // Opcodes
    //////////////////////////////////////////////////

    // Register-register form takes both operands from the sources
    localparam logic [OPC_W-1:0] OPC_REG = 12'h033;

    // Register-immediate form, the immediate takes the place of source 2
    localparam logic [OPC_W-1:0] OPC_IMM = 12'h013;

    //////////////////////////////////////////////////
    // ALU operation codes
    //////////////////////////////////////////////////

    localparam logic [ALUOP_W-1:0] ALU_ADD = 4'h0;
    localparam logic [ALUOP_W-1:0] ALU_SUB = 4'h1;
    localparam logic [ALUOP_W-1:0] ALU_AND = 4'h2;
    localparam logic [ALUOP_W-1:0] ALU_OR  = 4'h3;
    localparam logic [ALUOP_W-1:0] ALU_XOR = 4'h4;
    localparam logic [ALUOP_W-1:0] ALU_SLL = 4'h5;  // Shift amount is op2[4:0]
    localparam logic [ALUOP_W-1:0] ALU_SRL = 4'h6;  // Logical right shift
    localparam logic [ALUOP_W-1:0] ALU_SLT = 4'h7;  // Signed compare, result is 1 or 0

    // Any other operation code gives a zero result

    // Number of low operand bits used as a shift amount
    localparam int SHAMT_W = 5;

endpackage

// ==== design/dispatch_if.sv ====
`timescale 1ns/1ns

// One dispatched instruction on its way into the reservation station
interface dispatch_if;

    logic                         valid;     // Write strobe, only high on an accepted transfer
    logic [rs_pkg::OPC_W-1:0]     opcode;
    logic [rs_pkg::ALUOP_W-1:0]   aluop;
    logic [rs_pkg::TAG_W-1:0]     rob_tag;
    logic [rs_pkg::TAG_W-1:0]     src1_tag;  // Zero when src1_val is already valid
    logic [rs_pkg::XLEN-1:0]      src1_val;
    logic [rs_pkg::TAG_W-1:0]     src2_tag;
    logic [rs_pkg::XLEN-1:0]      src2_val;
    logic [rs_pkg::XLEN-1:0]      imm;
    logic                         full;      // Station has no free entry

    modport source (
        output valid, opcode, aluop, rob_tag,
        output src1_tag, src1_val, src2_tag, src2_val, imm,
        input  full
    );

    modport sink (
        input  valid, opcode, aluop, rob_tag,
        input  src1_tag, src1_val, src2_tag, src2_val, imm,
        output full
    );

endinterface

// ==== design/cdb_if.sv ====
`timescale 1ns/1ns

// Two-channel common data bus, a tag of zero marks an idle channel
interface cdb_if;

    logic [rs_pkg::TAG_W-1:0] c0_tag;  // Channel 0 carries the ALU result
    logic [rs_pkg::XLEN-1:0]  c0_val;
    logic [rs_pkg::TAG_W-1:0] c1_tag;  // Channel 1 stands for a second functional unit
    logic [rs_pkg::XLEN-1:0]  c1_val;

    modport listener (
        input c0_tag, c0_val,
        input c1_tag, c1_val
    );

    modport c0_driver (
        output c0_tag, c0_val
    );

endinterface

// ==== design/issue_if.sv ====
`timescale 1ns/1ns

// One instruction with both operands resolved, headed for the ALU
interface issue_if;

    logic                       valid;
    logic [rs_pkg::OPC_W-1:0]   opcode;
    logic [rs_pkg::ALUOP_W-1:0] aluop;
    logic [rs_pkg::TAG_W-1:0]   rob_tag;
    logic [rs_pkg::XLEN-1:0]    val1;
    logic [rs_pkg::XLEN-1:0]    val2;
    logic [rs_pkg::XLEN-1:0]    imm;

    modport source (
        output valid, opcode, aluop, rob_tag,
        output val1, val2, imm
    );

    modport sink (
        input valid, opcode, aluop, rob_tag,
        input val1, val2, imm
    );

endinterface

// ==== design/dispatch_stage.sv ====
`timescale 1ns/1ns

module dispatch_stage (
    input  logic                         disp_valid,
    input  logic [rs_pkg::OPC_W-1:0]     disp_opcode,
    input  logic [rs_pkg::ALUOP_W-1:0]   disp_aluop,
    input  logic [rs_pkg::TAG_W-1:0]     disp_rob_tag,
    input  logic [rs_pkg::TAG_W-1:0]     disp_src1_tag,
    input  logic [rs_pkg::XLEN-1:0]      disp_src1_val,
    input  logic [rs_pkg::TAG_W-1:0]     disp_src2_tag,
    input  logic [rs_pkg::XLEN-1:0]      disp_src2_val,
    input  logic [rs_pkg::XLEN-1:0]      disp_imm,
    output logic                         disp_ready,
    dispatch_if.source                   disp,
    cdb_if.listener                      cdb
);

    logic [rs_pkg::TAG_W-1:0] src2_tag_raw;

    // True when a waiting source matches a live broadcast tag
    function automatic logic tag_hit(
        input logic [rs_pkg::TAG_W-1:0] src_tag,
        input logic [rs_pkg::TAG_W-1:0] bus_tag
    );
        return (src_tag != '0) && (src_tag == bus_tag);
    endfunction

    //////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////

    assign disp_ready = !disp.full;
    assign disp.valid = disp_valid && !disp.full;  // Station writes on every high cycle

    assign disp.opcode  = disp_opcode;
    assign disp.aluop   = disp_aluop;
    assign disp.rob_tag = disp_rob_tag;
    assign disp.imm     = disp_imm;

    // The immediate form never waits on source 2
    assign src2_tag_raw = (disp_opcode == rs_pkg::OPC_IMM) ? '0 : disp_src2_tag;

    //////////////////////////////////////////////////
    // Same-cycle bypass, channel 0 wins a double hit
    //////////////////////////////////////////////////

    always_comb begin
        disp.src1_tag = disp_src1_tag;
        disp.src1_val = disp_src1_val;
        if (tag_hit(disp_src1_tag, cdb.c0_tag)) begin
            disp.src1_tag = '0;
            disp.src1_val = cdb.c0_val;
        end else if (tag_hit(disp_src1_tag, cdb.c1_tag)) begin
            disp.src1_tag = '0;
            disp.src1_val = cdb.c1_val;
        end
    end

    always_comb begin
        disp.src2_tag = src2_tag_raw;
        disp.src2_val = disp_src2_val;
        if (tag_hit(src2_tag_raw, cdb.c0_tag)) begin
            disp.src2_tag = '0;
            disp.src2_val = cdb.c0_val;
        end else if (tag_hit(src2_tag_raw, cdb.c1_tag)) begin
            disp.src2_tag = '0;
            disp.src2_val = cdb.c1_val;
        end
    end

endmodule

// ==== design/reservation_station.sv ====
`timescale 1ns/1ns

module reservation_station #(
    parameter int RS_DEPTH = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    dispatch_if.sink    disp,
    cdb_if.listener     cdb,
    issue_if.source     issue
);

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    // Entry storage
    logic [RS_DEPTH-1:0]        busy;
    logic [rs_pkg::OPC_W-1:0]   ent_opcode   [RS_DEPTH];
    logic [rs_pkg::ALUOP_W-1:0] ent_aluop    [RS_DEPTH];
    logic [rs_pkg::TAG_W-1:0]   ent_rob_tag  [RS_DEPTH];
    logic [rs_pkg::TAG_W-1:0]   ent_src1_tag [RS_DEPTH];
    logic [rs_pkg::XLEN-1:0]    ent_src1_val [RS_DEPTH];
    logic [rs_pkg::TAG_W-1:0]   ent_src2_tag [RS_DEPTH];
    logic [rs_pkg::XLEN-1:0]    ent_src2_val [RS_DEPTH];
    logic [rs_pkg::XLEN-1:0]    ent_imm      [RS_DEPTH];

    logic [RS_DEPTH-1:0] ready;
    logic [IDX_W-1:0]    free_idx;
    logic                free_found;
    logic [IDX_W-1:0]    sel_idx;
    logic                sel_found;

    // Issue register
    logic                       iss_valid;
    logic [rs_pkg::OPC_W-1:0]   iss_opcode;
    logic [rs_pkg::ALUOP_W-1:0] iss_aluop;
    logic [rs_pkg::TAG_W-1:0]   iss_rob_tag;
    logic [rs_pkg::XLEN-1:0]    iss_val1;
    logic [rs_pkg::XLEN-1:0]    iss_val2;
    logic [rs_pkg::XLEN-1:0]    iss_imm;

    function automatic logic tag_hit(
        input logic [rs_pkg::TAG_W-1:0] src_tag,
        input logic [rs_pkg::TAG_W-1:0] bus_tag
    );
        return (src_tag != '0) && (src_tag == bus_tag);
    endfunction

    //////////////////////////////////////////////////
    // Allocation and selection
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ready[i] = busy[i] && (ent_src1_tag[i] == '0) && (ent_src2_tag[i] == '0);
        end
    end

    // Later hits overwrite earlier ones, so the highest index wins both searches
    always_comb begin
        free_idx   = '0;
        free_found = 1'b0;
        sel_idx    = '0;
        sel_found  = 1'b0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (!busy[i]) begin
                free_idx   = IDX_W'(i);
                free_found = 1'b1;
            end
            if (ready[i]) begin
                sel_idx   = IDX_W'(i);
                sel_found = 1'b1;
            end
        end
    end

    assign disp.full = !free_found;

    //////////////////////////////////////////////////
    // Busy bits
    //////////////////////////////////////////////////

    // The selected entry is busy, so it never collides with the free one
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (flush) begin
                busy <= '0;
            end else if (sel_found) begin
                busy[sel_idx] <= 1'b0;  // Freed as it moves to the issue register
            end
            if (disp.valid) begin
                busy[free_idx] <= 1'b1;  // Dispatch in the flush cycle survives
            end
        end
    end

    //////////////////////////////////////////////////
    // Wakeup and entry write
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (busy[i]) begin
                if (tag_hit(ent_src1_tag[i], cdb.c0_tag)) begin
                    ent_src1_val[i] <= cdb.c0_val;
                    ent_src1_tag[i] <= '0;
                end else if (tag_hit(ent_src1_tag[i], cdb.c1_tag)) begin
                    ent_src1_val[i] <= cdb.c1_val;
                    ent_src1_tag[i] <= '0;
                end
                if (tag_hit(ent_src2_tag[i], cdb.c0_tag)) begin
                    ent_src2_val[i] <= cdb.c0_val;
                    ent_src2_tag[i] <= '0;
                end else if (tag_hit(ent_src2_tag[i], cdb.c1_tag)) begin
                    ent_src2_val[i] <= cdb.c1_val;
                    ent_src2_tag[i] <= '0;
                end
            end
        end
        if (disp.valid) begin
            ent_opcode[free_idx]   <= disp.opcode;
            ent_aluop[free_idx]    <= disp.aluop;
            ent_rob_tag[free_idx]  <= disp.rob_tag;
            ent_src1_tag[free_idx] <= disp.src1_tag;  // Already bypassed by the input side
            ent_src1_val[free_idx] <= disp.src1_val;
            ent_src2_tag[free_idx] <= disp.src2_tag;
            ent_src2_val[free_idx] <= disp.src2_val;
            ent_imm[free_idx]      <= disp.imm;
        end
    end

    //////////////////////////////////////////////////
    // Issue register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= sel_found && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_found) begin
            iss_opcode  <= ent_opcode[sel_idx];
            iss_aluop   <= ent_aluop[sel_idx];
            iss_rob_tag <= ent_rob_tag[sel_idx];
            iss_val1    <= ent_src1_val[sel_idx];
            iss_val2    <= ent_src2_val[sel_idx];
            iss_imm     <= ent_imm[sel_idx];
        end
    end

    assign issue.valid   = iss_valid;
    assign issue.opcode  = iss_opcode;
    assign issue.aluop   = iss_aluop;
    assign issue.rob_tag = iss_rob_tag;
    assign issue.val1    = iss_val1;
    assign issue.val2    = iss_val2;
    assign issue.imm     = iss_imm;

endmodule

// ==== design/alu_unit.sv ====
`timescale 1ns/1ns

module alu_unit (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    issue_if.sink       issue,
    cdb_if.c0_driver    cdb
);

    logic [rs_pkg::XLEN-1:0]    op2;
    logic [rs_pkg::XLEN-1:0]    alu_res;
    logic [rs_pkg::SHAMT_W-1:0] shamt;
    logic [rs_pkg::TAG_W-1:0]   res_tag;
    logic [rs_pkg::XLEN-1:0]    res_val;

    //////////////////////////////////////////////////
    // Operand select and compute
    //////////////////////////////////////////////////

    assign op2   = (issue.opcode == rs_pkg::OPC_IMM) ? issue.imm : issue.val2;
    assign shamt = op2[rs_pkg::SHAMT_W-1:0];

    always_comb begin
        alu_res = '0;  // Unlisted operations give zero
        case (issue.aluop)
            rs_pkg::ALU_ADD: alu_res = issue.val1 + op2;
            rs_pkg::ALU_SUB: alu_res = issue.val1 - op2;
            rs_pkg::ALU_AND: alu_res = issue.val1 & op2;
            rs_pkg::ALU_OR:  alu_res = issue.val1 | op2;
            rs_pkg::ALU_XOR: alu_res = issue.val1 ^ op2;
            rs_pkg::ALU_SLL: alu_res = issue.val1 << shamt;
            rs_pkg::ALU_SRL: alu_res = issue.val1 >> shamt;
            rs_pkg::ALU_SLT: alu_res[0] = $signed(issue.val1) < $signed(op2);
            default:         alu_res = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Result register onto channel 0
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_tag <= '0;
        end else if (flush || !issue.valid) begin
            res_tag <= '0;  // Idle bus
        end else begin
            res_tag <= issue.rob_tag;
        end
    end

    // Value only matters while the tag is nonzero
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            res_val <= alu_res;
        end
    end

    assign cdb.c0_tag = res_tag;
    assign cdb.c0_val = res_val;

endmodule

// ==== design/rs_alu_top.sv ====
`timescale 1ns/1ns

module rs_alu_top #(
    parameter int RS_DEPTH = 16  // At most 2**TAG_W - 1
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         disp_valid,
    input  logic [rs_pkg::OPC_W-1:0]     disp_opcode,
    input  logic [rs_pkg::ALUOP_W-1:0]   disp_aluop,
    input  logic [rs_pkg::TAG_W-1:0]     disp_rob_tag,
    input  logic [rs_pkg::TAG_W-1:0]     disp_src1_tag,
    input  logic [rs_pkg::XLEN-1:0]      disp_src1_val,
    input  logic [rs_pkg::TAG_W-1:0]     disp_src2_tag,
    input  logic [rs_pkg::XLEN-1:0]      disp_src2_val,
    input  logic [rs_pkg::XLEN-1:0]      disp_imm,
    input  logic [rs_pkg::TAG_W-1:0]     ext_cdb_tag,
    input  logic [rs_pkg::XLEN-1:0]      ext_cdb_val,
    input  logic                         flush,
    output logic                         disp_ready,
    output logic                         result_valid,
    output logic [rs_pkg::TAG_W-1:0]     result_tag,
    output logic [rs_pkg::XLEN-1:0]      result_value
);

    dispatch_if disp_bus ();
    cdb_if      cdb_bus ();
    issue_if    issue_bus ();

    // Channel 1 comes straight from outside
    assign cdb_bus.c1_tag = ext_cdb_tag;
    assign cdb_bus.c1_val = ext_cdb_val;

    // The result output mirrors channel 0
    assign result_valid = (cdb_bus.c0_tag != '0);
    assign result_tag   = cdb_bus.c0_tag;
    assign result_value = cdb_bus.c0_val;

    dispatch_stage i_dispatch_stage (
        .disp_valid    (disp_valid),
        .disp_opcode   (disp_opcode),
        .disp_aluop    (disp_aluop),
        .disp_rob_tag  (disp_rob_tag),
        .disp_src1_tag (disp_src1_tag),
        .disp_src1_val (disp_src1_val),
        .disp_src2_tag (disp_src2_tag),
        .disp_src2_val (disp_src2_val),
        .disp_imm      (disp_imm),
        .disp_ready    (disp_ready),
        .disp          (disp_bus.source),
        .cdb           (cdb_bus.listener)
    );

    reservation_station #(
        .RS_DEPTH (RS_DEPTH)
    ) i_reservation_station (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .disp  (disp_bus.sink),
        .cdb   (cdb_bus.listener),
        .issue (issue_bus.source)
    );

    alu_unit i_alu_unit (
        .clk   (clk),
        .rst   (rst),
        .flush (flush),
        .issue (issue_bus.sink),
        .cdb   (cdb_bus.c0_driver)
    );

endmodule

// ==== tests/rs_alu_tb.sv ====
`timescale 1ns/1ns

module rs_alu_tb;

    typedef logic [rs_pkg::TAG_W-1:0]   tag_t;
    typedef logic [rs_pkg::XLEN-1:0]    word_t;
    typedef logic [rs_pkg::OPC_W-1:0]   opc_t;
    typedef logic [rs_pkg::ALUOP_W-1:0] aluop_t;

    localparam int NTAGS = 2 ** rs_pkg::TAG_W;

    localparam logic [2:0] K_OP    = 3'd0;  // Dispatch with free latency
    localparam logic [2:0] K_FIX   = 3'd1;  // Dispatch whose result is due two cycles after acceptance
    localparam logic [2:0] K_IDLE  = 3'd2;
    localparam logic [2:0] K_FLUSH = 3'd3;
    localparam logic [2:0] K_DRAIN = 3'd4;  // Hold idle until every pending result is in

    typedef struct packed {
        logic [2:0] kind;
        opc_t       opc;
        aluop_t     aluop;
        tag_t       rob;
        tag_t       s1t;
        word_t      s1v;
        tag_t       s2t;
        word_t      s2v;
        word_t      imm;
        tag_t       ext_t;  // Channel 1 broadcast driven in this row's cycle
        word_t      ext_v;
        word_t      result;
    } row_t;

    logic   clk, rst, flush, disp_valid, disp_ready, result_valid;
    opc_t   disp_opcode;
    aluop_t disp_aluop;
    tag_t   disp_rob_tag, disp_src1_tag, disp_src2_tag, ext_cdb_tag, result_tag;
    word_t  disp_src1_val, disp_src2_val, disp_imm, ext_cdb_val, result_value;

    row_t   rows [$];
    string  row_name [$];
    integer seed = 32'h0631_bcf5;
    int     cyc = 0;
    int     limit = 0;
    int     pending = 0;
    bit     saw_full = 1'b0;
    int     fix_cyc [$];
    tag_t   fix_tag [$];

    // Scoreboard indexed by ROBEN where state 0 is idle, 1 is pending and 2 is done
    int     tag_state [NTAGS];
    word_t  exp_val [NTAGS];
    tag_t   wait1 [NTAGS];
    tag_t   wait2 [NTAGS];
    int     row_of [NTAGS];
    bit     seen [NTAGS];    // Tag has been broadcast since its last dispatch
    word_t  model [NTAGS];

    rs_alu_top i_rs_alu_top (.*);

    always #4 clk = ~clk;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    task automatic check_tag(input string name, input tag_t expected, input tag_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected tag %0d, actual tag %0d", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "result tag mismatch");
        end
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %08h, actual %08h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "result value mismatch");
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    // Reference ALU model
    function automatic word_t ref_alu(input aluop_t op, input word_t a, input word_t b);
        word_t res;
        case (op)
            rs_pkg::ALU_ADD: res = a + b;
            rs_pkg::ALU_SUB: res = a - b;
            rs_pkg::ALU_AND: res = a & b;
            rs_pkg::ALU_OR:  res = a | b;
            rs_pkg::ALU_XOR: res = a ^ b;
            rs_pkg::ALU_SLL: res = a << b[4:0];
            rs_pkg::ALU_SRL: res = a >> b[4:0];
            rs_pkg::ALU_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:         res = '0;
        endcase
        return res;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    task automatic add_row(input string name, input logic [2:0] kind, input opc_t opc,
                           input int op, input int rob, input int s1t, input int s2t,
                           input int ext_t);
        row_t r;
        r = '0;
        r.kind  = kind;
        r.opc   = opc;
        r.aluop = aluop_t'(op);
        r.rob   = tag_t'(rob);
        r.s1t   = tag_t'(s1t);
        r.s2t   = tag_t'(s2t);
        r.s1v   = $random(seed);
        r.s2v   = $random(seed);
        r.imm   = $random(seed);
        r.ext_t = tag_t'(ext_t);
        if (ext_t != 0) r.ext_v = $random(seed);
        rows.push_back(r);
        row_name.push_back(name);
    endtask

    task automatic build_table();
        // Every operation in both forms with ready operands uses tags 1 to 16
        for (int f = 0; f < 2; f++) begin
            for (int op = 0; op < 8; op++) begin
                add_row($sformatf("alu_op%0d_%s", op, (f != 0) ? "imm" : "reg"), K_FIX,
                        (f != 0) ? rs_pkg::OPC_IMM : rs_pkg::OPC_REG, op, 1 + 8 * f + op,
                        0, 0, 0);
            end
        end
        add_row("drain", K_DRAIN, '0, 0, 0, 0, 0, 0);
        add_row("wait_ext_reg", K_OP, rs_pkg::OPC_REG, 0, 1, 24, 25, 0);
        add_row("wait_ext_imm", K_OP, rs_pkg::OPC_IMM, 4, 2, 24, 0, 0);
        add_row("idle", K_IDLE, '0, 0, 0, 0, 0, 0);
        add_row("idle", K_IDLE, '0, 0, 0, 0, 0, 0);
        add_row("bcast_24", K_IDLE, '0, 0, 0, 0, 0, 24);
        add_row("idle", K_IDLE, '0, 0, 0, 0, 0, 0);
        add_row("bcast_25", K_IDLE, '0, 0, 0, 0, 0, 25);
        add_row("drain", K_DRAIN, '0, 0, 0, 0, 0, 0);
        // Each link waits on the ROBEN dispatched one cycle earlier
        add_row("chain_head", K_OP, rs_pkg::OPC_REG, 1, 3, 0, 0, 0);
        add_row("chain_or", K_OP, rs_pkg::OPC_REG, 3, 4, 3, 0, 0);
        add_row("chain_sll", K_OP, rs_pkg::OPC_REG, 5, 5, 4, 4, 0);
        add_row("chain_slt", K_OP, rs_pkg::OPC_IMM, 7, 6, 5, 0, 0);
        add_row("chain_add", K_OP, rs_pkg::OPC_REG, 0, 7, 6, 6, 0);
        add_row("drain", K_DRAIN, '0, 0, 0, 0, 0, 0);
        add_row("bypass_src1", K_OP, rs_pkg::OPC_REG, 2, 8, 26, 0, 26);
        add_row("bypass_src2", K_OP, rs_pkg::OPC_REG, 1, 9, 0, 27, 27);
        add_row("drain", K_DRAIN, '0, 0, 0, 0, 0, 0);
        for (int i = 1; i <= 16; i++) begin
            add_row($sformatf("fill_%0d", i), K_OP,
                    (i % 2 != 0) ? rs_pkg::OPC_IMM : rs_pkg::OPC_REG, i % 8, i, 28, 0, 0);
        end
        // Stalls on the full station while its broadcast releases the waiting entries
        add_row("release", K_OP, rs_pkg::OPC_REG, 0, 17, 0, 0, 28);
        add_row("drain", K_DRAIN, '0, 0, 0, 0, 0, 0);
        add_row("flushed_a", K_OP, rs_pkg::OPC_REG, 0, 18, 29, 0, 0);
        add_row("flushed_b", K_OP, rs_pkg::OPC_REG, 1, 19, 0, 30, 0);
        add_row("idle", K_IDLE, '0, 0, 0, 0, 0, 0);
        add_row("flush", K_FLUSH, '0, 0, 0, 0, 0, 0);
        add_row("after_flush_a", K_FIX, rs_pkg::OPC_REG, 4, 21, 0, 0, 0);
        add_row("after_flush_b", K_FIX, rs_pkg::OPC_IMM, 6, 20, 0, 0, 0);
        // A flushed entry that survived would wake on these and report tag 18 or 19
        add_row("bcast_29", K_IDLE, '0, 0, 0, 0, 0, 29);
        add_row("bcast_30", K_IDLE, '0, 0, 0, 0, 0, 30);
        add_row("drain", K_DRAIN, '0, 0, 0, 0, 0, 0);
    endtask

    task automatic compute_expected();
        row_t  r;
        word_t a;
        word_t b;
        foreach (model[i]) model[i] = '0;
        foreach (rows[i]) begin
            if (rows[i].ext_t != '0) model[rows[i].ext_t] = rows[i].ext_v;
        end
        // Walking in program order resolves each producer before its consumers
        foreach (rows[i]) begin
            r = rows[i];
            if (r.kind == K_OP || r.kind == K_FIX) begin
                a = (r.s1t != '0) ? model[r.s1t] : r.s1v;
                b = (r.s2t != '0) ? model[r.s2t] : r.s2v;
                if (r.opc == rs_pkg::OPC_IMM) b = r.imm;
                r.result = ref_alu(r.aluop, a, b);
                model[r.rob] = r.result;
                rows[i] = r;
            end
        end
    endtask

    task automatic accept_row(input int idx, input row_t r);
        tag_t t;
        t = r.rob;
        tag_state[t] = 1;
        exp_val[t]   = r.result;
        wait1[t]     = r.s1t;
        wait2[t]     = (r.opc == rs_pkg::OPC_IMM) ? '0 : r.s2t;
        row_of[t]    = idx;
        seen[t]      = 1'b0;
        pending++;
        if (r.kind == K_FIX) begin
            fix_cyc.push_back(cyc + 3);  // Valid after edge N+2 and sampled at N+3
            fix_tag.push_back(t);
        end
    endtask

    task automatic cancel_pending();
        for (int i = 0; i < NTAGS; i++) begin
            if (tag_state[i] == 1) begin
                tag_state[i] = 0;
                pending--;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Monitor and cycle limit
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        tag_t t;
        if (!rst) begin
            if (fix_cyc.size() > 0 && fix_cyc[0] == cyc) begin
                check_tag(row_name[row_of[fix_tag[0]]], fix_tag[0], result_tag);
                fix_cyc.delete(0);
                fix_tag.delete(0);
            end
            if (result_valid) begin
                t = result_tag;
                if (tag_state[t] == 0) begin
                    abort_run($sformatf("Result for tag %0d that is not in flight", t));
                end else if (tag_state[t] == 2) begin
                    abort_run($sformatf("Tag %0d produced a second result", t));
                end
                if ((wait1[t] != '0 && !seen[wait1[t]]) ||
                    (wait2[t] != '0 && !seen[wait2[t]])) begin
                    abort_run($sformatf("Tag %0d completed before its source was broadcast", t));
                end
                check_value(row_name[row_of[t]], exp_val[t], result_value);
                tag_state[t] = 2;
                seen[t] = 1'b1;
                pending--;
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= limit) begin
            $display("Timeout after %0d cycles, %0d results never arrived", cyc, pending);
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        row_t cur;
        logic is_disp;
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        disp_valid = 1'b0;
        disp_opcode = '0;
        disp_aluop = '0;
        disp_rob_tag = '0;
        disp_src1_tag = '0;
        disp_src1_val = '0;
        disp_src2_tag = '0;
        disp_src2_val = '0;
        disp_imm = '0;
        ext_cdb_tag = '0;
        ext_cdb_val = '0;
        foreach (tag_state[i]) begin
            tag_state[i] = 0;
            seen[i] = 1'b0;
        end
        build_table();
        compute_expected();
        limit = 20 * rows.size() + 200;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (!disp_ready || result_valid) abort_run("Outputs not idle after reset");
        for (int r = 0; r < rows.size(); r++) begin
            cur = rows[r];
            is_disp = (cur.kind == K_OP) || (cur.kind == K_FIX);
            if (cur.kind == K_DRAIN) begin
                disp_valid  <= 1'b0;
                ext_cdb_tag <= '0;
                flush       <= 1'b0;
                @(negedge clk);
                while (pending != 0) @(negedge clk);
                @(posedge clk);
            end else begin
                disp_valid    <= is_disp;
                disp_opcode   <= cur.opc;
                disp_aluop    <= cur.aluop;
                disp_rob_tag  <= cur.rob;
                disp_src1_tag <= cur.s1t;
                disp_src1_val <= cur.s1v;
                disp_src2_tag <= cur.s2t;
                disp_src2_val <= cur.s2v;
                disp_imm      <= cur.imm;
                ext_cdb_tag   <= cur.ext_t;
                ext_cdb_val   <= cur.ext_v;
                flush         <= (cur.kind == K_FLUSH);
                if (cur.ext_t != '0) seen[cur.ext_t] = 1'b1;
                @(posedge clk);
                while (is_disp && !disp_ready) begin
                    saw_full = 1'b1;  // Row holds until the station frees an entry
                    @(posedge clk);
                end
                if (is_disp) accept_row(r, cur);
                if (cur.kind == K_FLUSH) cancel_pending();
            end
        end
        repeat (20) @(posedge clk);  // Room for a stray result from a flushed entry
        if (!saw_full) abort_run("disp_ready never went low with the station full");
        if (disp_ready) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("disp_ready stayed low after the station drained");
            $display("Simulation failed");
            $fatal(1, "dispatch still blocked");
        end
    end

endmodule

// ==== filelist.f ====
design/rs_pkg.sv
design/dispatch_if.sv
design/cdb_if.sv
design/issue_if.sv
design/dispatch_stage.sv
design/reservation_station.sv
design/alu_unit.sv
design/rs_alu_top.sv
tests/rs_alu_tb.sv

// ==== Makefile ====
# Verilator build and run of the reservation station testbench

OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -f filelist.f --top-module rs_alu_tb \
		-Mdir $(OBJ_DIR) -o rs_alu_sim
	./$(OBJ_DIR)/rs_alu_sim

clean:
	rm -rf $(OBJ_DIR)
